// File: vector_lane.f
rtl/vlane_pkg.sv
rtl/lane_sequencer.sv
rtl/operand_requester.sv
rtl/vector_regfile.sv
rtl/operand_queues.sv
rtl/lane_alu.sv
rtl/vector_lane.sv
testbench/vector_lane_sva.sv
testbench/vector_lane_tb.sv

// File: run.sh
#!/bin/sh
# Compile the vector lane testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module vector_lane_tb -Mdir obj_dir -o vector_lane_sim -f vector_lane.f

status=0
./obj_dir/vector_lane_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"

// File: testbench/vector_lane_tests.txt
// Records: 1 addr data be | 2 op sew vd vs1 vs2 vl id | 3 vs2 vl id expected_words | 0 end
// addr is {vreg, word}; op 0 ADD 1 SUB 2 AND 3 OR 4 XOR; sew 0 is 16 bit, 1 is 32 bit
1 08 0001000100010001 ff
1 09 0000000100000001 ff
1 0a 0f0f0f0f0f0f0f0f ff
1 0b 1234567890abcdef ff
1 0c ffffffffffffffff ff
1 0d 7fffffff0000ffff ff
1 0e 5555555555555555 ff
1 0f 0000000000000000 ff
1 0e ff00ff00ff00ff00 0f
1 0f 0123456789abcdef c3
3 03 4 1 ffffffffffffffff 7fffffff0000ffff 55555555ff00ff00 012300000000cdef
2 0 0 04 02 03 4 2
3 04 4 3 0000000000000000 7fff000000000000 646464640e0f0e0f 1357567890ab9bde
2 0 1 05 02 03 4 4
3 05 4 5 0001000000010000 8000000000010000 646464640e100e0f 1357567890ac9bde
2 1 0 06 02 03 4 6
3 06 4 7 fffefffefffefffe 7ffffffe0000fffe 46464646eff1eff1 eeefa9886f550000
2 1 1 07 02 03 4 0
3 07 4 1 fffefffefffefffe 7ffffffe0000fffe 46464646eff1eff1 eeeea9886f550000
2 2 0 08 02 03 4 2
3 08 4 3 0001000100010001 0000000100000001 050505050f000f00 002000000000cdef
2 3 0 09 02 03 4 4
3 09 3 5 ffffffffffffffff 7fffffff0000ffff 5f5f5f5fff0fff0f
2 4 0 02 02 03 2 6
3 02 4 7 fffefffefffefffe 7ffffffe0000fffe 0f0f0f0f0f0f0f0f 1234567890abcdef
0

// File: testbench/vector_lane_tb.sv
/*
 * Testbench for the vector lane: clock and reset, load, ALU and store
 * records read from the test file, random store back-pressure,
 * response checks and the closing summary.
 */

`timescale 1ns/100ps

module vector_lane_tb import vlane_pkg::*; ();

  localparam int TimeoutCycles = 200;
  localparam int MaxWords      = 256;

  logic                  clk_i, rst_n_i;
  logic [OpWidth-1:0]    pe_req_op_i;
  logic [SewWidth-1:0]   pe_req_sew_i;
  logic [VRegWidth-1:0]  pe_req_vd_i, pe_req_vs1_i, pe_req_vs2_i;
  logic [VlWidth-1:0]    pe_req_vl_i;
  logic [IdWidth-1:0]    pe_req_id_i, pe_resp_id_o;
  logic                  pe_req_valid_i, pe_req_ready_o, pe_resp_valid_o;
  logic                  ldu_req_i, ldu_gnt_o;
  logic [VAddrWidth-1:0] ldu_addr_i;
  logic [ElenWidth-1:0]  ldu_wdata_i, stu_operand_o;
  logic [StrbWidth-1:0]  ldu_be_i;
  logic                  stu_operand_valid_o, stu_operand_ready_i;

  logic [ElenWidth-1:0]  tests_q [MaxWords];
  logic [ElenWidth-1:0]  got_q [$];
  int                    error_cnt, check_cnt, seed;
  logic                  timed_out;

  vector_lane UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [ElenWidth-1:0] exp,
                               input logic [ElenWidth-1:0] got);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    error_cnt++;
    timed_out = 1'b1;
    $display("ERROR t=%0t timed out after %0d cycles waiting for %s",
             $time, TimeoutCycles, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, driven on the falling edge and sampled 1 ns later
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_word(input logic [VAddrWidth-1:0] addr,
                           input logic [ElenWidth-1:0] data,
                           input logic [StrbWidth-1:0] be);
    int   cycles;
    logic granted;
    cycles  = 0;
    granted = 1'b0;
    @(negedge clk_i);
    ldu_req_i   = 1'b1;
    ldu_addr_i  = addr;
    ldu_wdata_i = data;
    ldu_be_i    = be;
    // Word is written on the rising edge after gnt is seen
    while (!granted && !timed_out) begin
      #1;
      if (ldu_gnt_o) granted = 1'b1;
      @(negedge clk_i);
      cycles++;
      if (!granted && cycles > TimeoutCycles) report_timeout("ldu_gnt_o");
    end
    ldu_req_i = 1'b0;
  endtask

  // Issues one instruction and collects store words until the response
  task automatic run_instr(input logic [OpWidth-1:0] op, input logic [SewWidth-1:0] sew,
                           input logic [VRegWidth-1:0] vd, input logic [VRegWidth-1:0] vs1,
                           input logic [VRegWidth-1:0] vs2, input logic [VlWidth-1:0] vl,
                           input logic [IdWidth-1:0] id);
    int          cycles;
    int          resp_cnt;
    logic        accepted;
    logic [31:0] stall;
    got_q.delete();
    cycles   = 0;
    resp_cnt = 0;
    accepted = 1'b0;
    @(negedge clk_i);
    pe_req_op_i    = op;
    pe_req_sew_i   = sew;
    pe_req_vd_i    = vd;
    pe_req_vs1_i   = vs1;
    pe_req_vs2_i   = vs2;
    pe_req_vl_i    = vl;
    pe_req_id_i    = id;
    pe_req_valid_i = 1'b1;
    while (!accepted && !timed_out) begin
      #1;
      if (pe_req_ready_o) accepted = 1'b1;
      @(negedge clk_i);
      cycles++;
      if (!accepted && cycles > TimeoutCycles) report_timeout("pe_req_ready_o");
    end
    pe_req_valid_i = 1'b0;
    cycles = 0;
    while (resp_cnt == 0 && !timed_out) begin
      // Store port ready about three cycles in four
      stall = $random(seed);
      stu_operand_ready_i = (stall[1:0] != 2'b00);
      #1;
      check_cnt++;
      if (pe_req_ready_o !== 1'b0) begin
        error_cnt++;
        $display("FAIL t=%0t pe_req_ready_o expected 0 got %b", $time, pe_req_ready_o);
      end
      if (stu_operand_valid_o && stu_operand_ready_i) got_q.push_back(stu_operand_o);
      if (pe_resp_valid_o) begin
        resp_cnt++;
        compare_value("pe_resp_id_o", ElenWidth'(id), ElenWidth'(pe_resp_id_o));
      end
      @(negedge clk_i);
      cycles++;
      if (resp_cnt == 0 && cycles > TimeoutCycles) report_timeout("pe_resp_valid_o");
    end
    // Quiet cycles after completion
    stu_operand_ready_i = 1'b1;
    repeat (3) begin
      #1;
      check_cnt++;
      if (pe_resp_valid_o || stu_operand_valid_o) begin
        error_cnt++;
        $display("ERROR t=%0t extra response or store word after id %0d completed",
                 $time, id);
      end
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                   ptr;
    int                   k;
    logic                 done;
    logic [VlWidth-1:0]   vl;
    logic [ElenWidth-1:0] kind;
    seed      = 32'h5a07c9d2;
    error_cnt = 0;
    check_cnt = 0;
    timed_out = 1'b0;
    rst_n_i             = 1'b0;
    pe_req_valid_i      = 1'b0;
    pe_req_op_i         = '0;
    pe_req_sew_i        = '0;
    pe_req_vd_i         = '0;
    pe_req_vs1_i        = '0;
    pe_req_vs2_i        = '0;
    pe_req_vl_i         = '0;
    pe_req_id_i         = '0;
    ldu_req_i           = 1'b0;
    ldu_addr_i          = '0;
    ldu_wdata_i         = '0;
    ldu_be_i            = '0;
    stu_operand_ready_i = 1'b0;
    $readmemh("testbench/vector_lane_tests.txt", tests_q);

    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    compare_value("pe_req_ready_o", 64'd1, ElenWidth'(pe_req_ready_o));
    compare_value("pe_resp_valid_o", 64'd0, ElenWidth'(pe_resp_valid_o));
    compare_value("stu_operand_valid_o", 64'd0, ElenWidth'(stu_operand_valid_o));
    compare_value("ldu_gnt_o", 64'd0, ElenWidth'(ldu_gnt_o));
    @(negedge clk_i);

    ptr  = 0;
    done = 1'b0;
    while (!done && !timed_out) begin
      kind = tests_q[ptr];
      case (kind)
        64'd1: begin
          load_word(tests_q[ptr+1][VAddrWidth-1:0], tests_q[ptr+2],
                    tests_q[ptr+3][StrbWidth-1:0]);
          ptr += 4;
        end
        64'd2: begin
          run_instr(tests_q[ptr+1][OpWidth-1:0], tests_q[ptr+2][SewWidth-1:0],
                    tests_q[ptr+3][VRegWidth-1:0], tests_q[ptr+4][VRegWidth-1:0],
                    tests_q[ptr+5][VRegWidth-1:0], tests_q[ptr+6][VlWidth-1:0],
                    tests_q[ptr+7][IdWidth-1:0]);
          ptr += 8;
        end
        64'd3: begin
          vl = tests_q[ptr+2][VlWidth-1:0];
          run_instr(OpStore, Sew16, '0, '0, tests_q[ptr+1][VRegWidth-1:0], vl,
                    tests_q[ptr+3][IdWidth-1:0]);
          compare_value("store word count", ElenWidth'(vl), ElenWidth'(got_q.size()));
          for (k = 0; k < int'(vl) && k < got_q.size(); k++) begin
            compare_value($sformatf("stu_operand_o[%0d]", k), tests_q[ptr+4+k], got_q[k]);
          end
          ptr += 4 + int'(vl);
        end
        64'd0: done = 1'b1;
        default: begin
          error_cnt++;
          $display("ERROR unknown record kind %h at word %0d of the test file", kind, ptr);
          done = 1'b1;
        end
      endcase
    end

    $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/vector_lane_sva.sv
/*
 * Handshake assertions for the vector lane: load grant, store port
 * hold until ready, and response only from a busy lane.
 */

`timescale 1ns/100ps

module vector_lane_sva import vlane_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 ldu_req_i,
  input logic                 ldu_gnt_o,
  input logic [ElenWidth-1:0] stu_operand_o,
  input logic                 stu_operand_valid_o,
  input logic                 stu_operand_ready_i,
  input logic                 pe_req_ready_o,
  input logic                 pe_resp_valid_o
);

  // Grant only answers a pending load and comes at once on an idle lane
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ldu_gnt_o || (ldu_req_i && pe_req_ready_o) |-> ldu_gnt_o && ldu_req_i)
    else $error("ldu_gnt_o without ldu_req_i or load not granted while idle");

  // Store word held with stable data until taken
  stu_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stu_operand_valid_o && !stu_operand_ready_i |=>
      stu_operand_valid_o && $stable(stu_operand_o))
    else $error("store operand dropped or changed before ready");

  // Response closes a busy period and the lane is ready in the next cycle
  resp_only_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pe_resp_valid_o |=> pe_req_ready_o && !$past(pe_req_ready_o))
    else $error("pe_resp_valid_o while pe_req_ready_o is high or ready not restored");

endmodule

bind vector_lane vector_lane_sva i_vector_lane_sva (
  .clk_i               (clk_i              ),
  .rst_n_i             (rst_n_i            ),
  .ldu_req_i           (ldu_req_i          ),
  .ldu_gnt_o           (ldu_gnt_o          ),
  .stu_operand_o       (stu_operand_o      ),
  .stu_operand_valid_o (stu_operand_valid_o),
  .stu_operand_ready_i (stu_operand_ready_i),
  .pe_req_ready_o      (pe_req_ready_o     ),
  .pe_resp_valid_o     (pe_resp_valid_o    )
);

// File: rtl/vector_lane.sv
/*
 * Vector lane top level: sequencer, operand requester, register file,
 * operand queues and ALU.
 */

`timescale 1ns/100ps

module vector_lane import vlane_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Instruction and response
  input  logic [OpWidth-1:0]    pe_req_op_i,
  input  logic [SewWidth-1:0]   pe_req_sew_i,
  input  logic [VRegWidth-1:0]  pe_req_vd_i,
  input  logic [VRegWidth-1:0]  pe_req_vs1_i,
  input  logic [VRegWidth-1:0]  pe_req_vs2_i,
  input  logic [VlWidth-1:0]    pe_req_vl_i,
  input  logic [IdWidth-1:0]    pe_req_id_i,
  input  logic                  pe_req_valid_i,
  output logic                  pe_req_ready_o,
  output logic                  pe_resp_valid_o,
  output logic [IdWidth-1:0]    pe_resp_id_o,
  // Load writes
  input  logic                  ldu_req_i,
  input  logic [VAddrWidth-1:0] ldu_addr_i,
  input  logic [ElenWidth-1:0]  ldu_wdata_i,
  input  logic [StrbWidth-1:0]  ldu_be_i,
  output logic                  ldu_gnt_o,
  // Store port
  output logic [ElenWidth-1:0]  stu_operand_o,
  output logic                  stu_operand_valid_o,
  input  logic                  stu_operand_ready_i
);

  logic                  op_req_valid, op_req_ready, op_req_store;
  logic [VRegWidth-1:0]  op_req_vs1, op_req_vs2;
  logic [VlWidth-1:0]    op_req_vl;
  logic                  alu_cmd_valid, alu_done;
  logic [OpWidth-1:0]    alu_cmd_op;
  logic [SewWidth-1:0]   alu_cmd_sew;
  logic [VRegWidth-1:0]  alu_cmd_vd;
  logic [VlWidth-1:0]    alu_cmd_vl;
  logic                  vrf_req, vrf_wen, vrf_rvalid;
  logic [VAddrWidth-1:0] vrf_addr;
  logic [ElenWidth-1:0]  vrf_wdata, vrf_rdata;
  logic [StrbWidth-1:0]  vrf_be;
  logic [TgtWidth-1:0]   vrf_tgt, vrf_rtgt;
  logic [NrQueues-1:0]   queue_credit;
  logic [ElenWidth-1:0]  alu_a, alu_b, alu_res_wdata;
  logic                  alu_opnd_valid, alu_opnd_ready, stu_pop;
  logic                  alu_res_req, alu_res_gnt;
  logic [VAddrWidth-1:0] alu_res_addr;

  lane_sequencer i_lane_sequencer (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .pe_req_op_i     (pe_req_op_i    ),
    .pe_req_sew_i    (pe_req_sew_i   ),
    .pe_req_vd_i     (pe_req_vd_i    ),
    .pe_req_vs1_i    (pe_req_vs1_i   ),
    .pe_req_vs2_i    (pe_req_vs2_i   ),
    .pe_req_vl_i     (pe_req_vl_i    ),
    .pe_req_id_i     (pe_req_id_i    ),
    .pe_req_valid_i  (pe_req_valid_i ),
    .pe_req_ready_o  (pe_req_ready_o ),
    .pe_resp_valid_o (pe_resp_valid_o),
    .pe_resp_id_o    (pe_resp_id_o   ),
    .op_req_valid_o  (op_req_valid   ),
    .op_req_ready_i  (op_req_ready   ),
    .op_req_vs1_o    (op_req_vs1     ),
    .op_req_vs2_o    (op_req_vs2     ),
    .op_req_vl_o     (op_req_vl      ),
    .op_req_store_o  (op_req_store   ),
    .alu_cmd_valid_o (alu_cmd_valid  ),
    .alu_cmd_op_o    (alu_cmd_op     ),
    .alu_cmd_sew_o   (alu_cmd_sew    ),
    .alu_cmd_vd_o    (alu_cmd_vd     ),
    .alu_cmd_vl_o    (alu_cmd_vl     ),
    .alu_done_i      (alu_done       ),
    .stu_pop_i       (stu_pop        )
  );

  operand_requester i_operand_requester (
    .clk_i           (clk_i        ),
    .rst_n_i         (rst_n_i      ),
    .op_req_valid_i  (op_req_valid ),
    .op_req_ready_o  (op_req_ready ),
    .op_req_vs1_i    (op_req_vs1   ),
    .op_req_vs2_i    (op_req_vs2   ),
    .op_req_vl_i     (op_req_vl    ),
    .op_req_store_i  (op_req_store ),
    .queue_credit_i  (queue_credit ),
    .alu_res_req_i   (alu_res_req  ),
    .alu_res_addr_i  (alu_res_addr ),
    .alu_res_wdata_i (alu_res_wdata),
    .alu_res_gnt_o   (alu_res_gnt  ),
    .ldu_req_i       (ldu_req_i    ),
    .ldu_addr_i      (ldu_addr_i   ),
    .ldu_wdata_i     (ldu_wdata_i  ),
    .ldu_be_i        (ldu_be_i     ),
    .ldu_gnt_o       (ldu_gnt_o    ),
    .vrf_req_o       (vrf_req      ),
    .vrf_wen_o       (vrf_wen      ),
    .vrf_addr_o      (vrf_addr     ),
    .vrf_wdata_o     (vrf_wdata    ),
    .vrf_be_o        (vrf_be       ),
    .vrf_tgt_o       (vrf_tgt      )
  );

  vector_regfile i_vrf (
    .clk_i    (clk_i     ),
    .rst_n_i  (rst_n_i   ),
    .req_i    (vrf_req   ),
    .wen_i    (vrf_wen   ),
    .addr_i   (vrf_addr  ),
    .wdata_i  (vrf_wdata ),
    .be_i     (vrf_be    ),
    .tgt_i    (vrf_tgt   ),
    .rdata_o  (vrf_rdata ),
    .rvalid_o (vrf_rvalid),
    .rtgt_o   (vrf_rtgt  )
  );

  operand_queues i_operand_queues (
    .clk_i               (clk_i              ),
    .rst_n_i             (rst_n_i            ),
    .vrf_rdata_i         (vrf_rdata          ),
    .vrf_rvalid_i        (vrf_rvalid         ),
    .vrf_rtgt_i          (vrf_rtgt           ),
    .queue_credit_o      (queue_credit       ),
    .alu_a_o             (alu_a              ),
    .alu_b_o             (alu_b              ),
    .alu_opnd_valid_o    (alu_opnd_valid     ),
    .alu_opnd_ready_i    (alu_opnd_ready     ),
    .stu_operand_o       (stu_operand_o      ),
    .stu_operand_valid_o (stu_operand_valid_o),
    .stu_operand_ready_i (stu_operand_ready_i),
    .stu_pop_o           (stu_pop            )
  );

  lane_alu i_lane_alu (
    .clk_i        (clk_i         ),
    .rst_n_i      (rst_n_i       ),
    .cmd_valid_i  (alu_cmd_valid ),
    .cmd_op_i     (alu_cmd_op    ),
    .cmd_sew_i    (alu_cmd_sew   ),
    .cmd_vd_i     (alu_cmd_vd    ),
    .cmd_vl_i     (alu_cmd_vl    ),
    .a_i          (alu_a         ),
    .b_i          (alu_b         ),
    .opnd_valid_i (alu_opnd_valid),
    .opnd_ready_o (alu_opnd_ready),
    .res_req_o    (alu_res_req   ),
    .res_addr_o   (alu_res_addr  ),
    .res_wdata_o  (alu_res_wdata ),
    .res_gnt_i    (alu_res_gnt   ),
    .done_o       (alu_done      )
  );

endmodule

// File: rtl/lane_alu.sv
/*
 * Element-wise integer ALU (ADD, SUB, AND, OR, XOR) at 16 or 32 bit
 * elements, with a registered result written back over req/gnt.
 */

`timescale 1ns/100ps

module lane_alu import vlane_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cmd_valid_i,
  input  logic [OpWidth-1:0]    cmd_op_i,
  input  logic [SewWidth-1:0]   cmd_sew_i,
  input  logic [VRegWidth-1:0]  cmd_vd_i,
  input  logic [VlWidth-1:0]    cmd_vl_i,
  input  logic [ElenWidth-1:0]  a_i,
  input  logic [ElenWidth-1:0]  b_i,
  input  logic                  opnd_valid_i,
  output logic                  opnd_ready_o,
  output logic                  res_req_o,
  output logic [VAddrWidth-1:0] res_addr_o,
  output logic [ElenWidth-1:0]  res_wdata_o,
  input  logic                  res_gnt_i,
  output logic                  done_o
);

  logic                 busy_q, res_req_q, done_q;
  logic [VlWidth-1:0]   pop_idx_q, wr_cnt_q;
  logic [OpWidth-1:0]   op_q;
  logic [SewWidth-1:0]  sew_q;
  logic [VRegWidth-1:0] vd_q;
  logic [VlWidth-1:0]   vl_q;
  alu_word_u            opa, opb, res;
  logic                 pop, last_gnt;

  // A held result blocks further pops
  assign opnd_ready_o = busy_q && !res_req_q;
  assign pop          = opnd_valid_i && opnd_ready_o;
  assign last_gnt     = res_req_q && res_gnt_i && ((wr_cnt_q + 1'b1) == vl_q);
  assign res_req_o    = res_req_q;
  assign done_o       = done_q;

  // A holds vs1, B holds vs2, SUB is vs2 - vs1
  always_comb begin
    opa.w = a_i;
    opb.w = b_i;
    res.w = '0;
    case (op_q)
      OpAdd, OpSub: begin
        if (sew_q == Sew32) begin
          for (int i = 0; i < 2; i++)
            res.e32[i] = (op_q == OpSub) ? opb.e32[i] - opa.e32[i] : opb.e32[i] + opa.e32[i];
        end else begin
          for (int i = 0; i < 4; i++)
            res.e16[i] = (op_q == OpSub) ? opb.e16[i] - opa.e16[i] : opb.e16[i] + opa.e16[i];
        end
      end
      OpAnd:   res.w = opa.w & opb.w;
      OpOr:    res.w = opa.w | opb.w;
      OpXor:   res.w = opa.w ^ opb.w;
      default: res.w = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      res_req_q <= 1'b0;
      done_q    <= 1'b0;
      pop_idx_q <= '0;
      wr_cnt_q  <= '0;
    end else begin
      done_q <= last_gnt;
      if (cmd_valid_i) begin
        busy_q    <= 1'b1;
        pop_idx_q <= '0;
        wr_cnt_q  <= '0;
      end
      if (pop) begin
        res_req_q <= 1'b1;
        pop_idx_q <= pop_idx_q + 1'b1;
      end else if (res_req_q && res_gnt_i) begin
        res_req_q <= 1'b0;
        wr_cnt_q  <= wr_cnt_q + 1'b1;
      end
      if (last_gnt) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_q  <= cmd_op_i;
      sew_q <= cmd_sew_i;
      vd_q  <= cmd_vd_i;
      vl_q  <= cmd_vl_i;
    end
    if (pop) begin
      res_wdata_o <= res.w;
      res_addr_o  <= {vd_q, pop_idx_q[WordIdxWidth-1:0]};
    end
  end

endmodule

// File: rtl/operand_queues.sv
/*
 * Operand queues: A and B feed the ALU and pop together, the third
 * feeds the store port. Each queue returns a credit to the requester.
 */

`timescale 1ns/100ps

module operand_queues import vlane_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [ElenWidth-1:0] vrf_rdata_i,
  input  logic                 vrf_rvalid_i,
  input  logic [TgtWidth-1:0]  vrf_rtgt_i,
  output logic [NrQueues-1:0]  queue_credit_o,
  output logic [ElenWidth-1:0] alu_a_o,
  output logic [ElenWidth-1:0] alu_b_o,
  output logic                 alu_opnd_valid_o,
  input  logic                 alu_opnd_ready_i,
  output logic [ElenWidth-1:0] stu_operand_o,
  output logic                 stu_operand_valid_o,
  input  logic                 stu_operand_ready_i,
  output logic                 stu_pop_o
);

  logic [ElenWidth-1:0] mem_q  [NrQueues][QueueDepth];
  logic [QPtrWidth-1:0] wptr_q [NrQueues];
  logic [QPtrWidth-1:0] rptr_q [NrQueues];
  logic [QCntWidth-1:0] cnt_q  [NrQueues];
  logic [NrQueues-1:0]  push, not_empty, q_pop;
  logic                 pop_alu, pop_st;

  always_comb begin
    for (int q = 0; q < NrQueues; q++) begin
      push[q]      = vrf_rvalid_i && (vrf_rtgt_i == TgtWidth'(q));
      not_empty[q] = (cnt_q[q] != '0);
      // A word arriving this cycle already holds an entry
      queue_credit_o[q] = (({1'b0, cnt_q[q]} + push[q]) < QueueDepth);
    end
  end

  assign alu_a_o          = mem_q[TgtA][rptr_q[TgtA]];
  assign alu_b_o          = mem_q[TgtB][rptr_q[TgtB]];
  assign alu_opnd_valid_o = not_empty[TgtA] && not_empty[TgtB];
  assign pop_alu          = alu_opnd_valid_o && alu_opnd_ready_i;

  assign stu_operand_o       = mem_q[TgtSt][rptr_q[TgtSt]];
  assign stu_operand_valid_o = not_empty[TgtSt];
  assign pop_st              = stu_operand_valid_o && stu_operand_ready_i;
  assign stu_pop_o           = pop_st;

  // Ordered as {store, B, A}
  assign q_pop = {pop_st, pop_alu, pop_alu};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int q = 0; q < NrQueues; q++) begin
        wptr_q[q] <= '0;
        rptr_q[q] <= '0;
        cnt_q[q]  <= '0;
      end
    end else begin
      for (int q = 0; q < NrQueues; q++) begin
        if (push[q])  wptr_q[q] <= wptr_q[q] + 1'b1;
        if (q_pop[q]) rptr_q[q] <= rptr_q[q] + 1'b1;
        cnt_q[q] <= cnt_q[q] + push[q] - q_pop[q];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrQueues; q++) begin
      if (push[q]) mem_q[q][wptr_q[q]] <= vrf_rdata_i;
    end
  end

endmodule

// File: rtl/vector_regfile.sv
/*
 * Single-port vector register file slice with byte-enable writes and a
 * registered read that returns the target queue tag with the data.
 */

`timescale 1ns/100ps

module vector_regfile import vlane_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  wen_i,
  input  logic [VAddrWidth-1:0] addr_i,
  input  logic [ElenWidth-1:0]  wdata_i,
  input  logic [StrbWidth-1:0]  be_i,
  input  logic [TgtWidth-1:0]   tgt_i,
  output logic [ElenWidth-1:0]  rdata_o,
  output logic                  rvalid_o,
  output logic [TgtWidth-1:0]   rtgt_o
);

  logic [ElenWidth-1:0] mem_q [NrVRegs*VRegWords];

  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
    if (req_i && !wen_i) begin
      rdata_o <= mem_q[addr_i];
      rtgt_o  <= tgt_i;
    end
  end

  // Read data valid one cycle after the request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rvalid_o <= 1'b0;
    else          rvalid_o <= req_i && !wen_i;
  end

endmodule

// File: rtl/operand_requester.sv
/*
 * Operand requester. Walks the VRF read addresses of the running
 * instruction and arbitrates the single VRF port between ALU
 * write-back, load writes and operand reads, in that order.
 */

`timescale 1ns/100ps

module operand_requester import vlane_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  op_req_valid_i,
  output logic                  op_req_ready_o,
  input  logic [VRegWidth-1:0]  op_req_vs1_i,
  input  logic [VRegWidth-1:0]  op_req_vs2_i,
  input  logic [VlWidth-1:0]    op_req_vl_i,
  input  logic                  op_req_store_i,
  input  logic [NrQueues-1:0]   queue_credit_i,
  input  logic                  alu_res_req_i,
  input  logic [VAddrWidth-1:0] alu_res_addr_i,
  input  logic [ElenWidth-1:0]  alu_res_wdata_i,
  output logic                  alu_res_gnt_o,
  input  logic                  ldu_req_i,
  input  logic [VAddrWidth-1:0] ldu_addr_i,
  input  logic [ElenWidth-1:0]  ldu_wdata_i,
  input  logic [StrbWidth-1:0]  ldu_be_i,
  output logic                  ldu_gnt_o,
  output logic                  vrf_req_o,
  output logic                  vrf_wen_o,
  output logic [VAddrWidth-1:0] vrf_addr_o,
  output logic [ElenWidth-1:0]  vrf_wdata_o,
  output logic [StrbWidth-1:0]  vrf_be_o,
  output logic [TgtWidth-1:0]   vrf_tgt_o
);

  logic                 busy_q, phase_q, store_q;
  logic [VRegWidth-1:0] vs1_q, vs2_q;
  logic [VlWidth-1:0]   vl_q, word_q;

  logic [TgtWidth-1:0]   rd_tgt;
  logic [VAddrWidth-1:0] rd_addr;
  logic                  rd_want, rd_fire, word_step;

  ////////////////////////////////////////////////////////////////////////////
  // Read address walk
  ////////////////////////////////////////////////////////////////////////////

  // ALU ops alternate vs1 word (queue A) and vs2 word (queue B)
  assign rd_tgt  = store_q ? TgtSt : (phase_q ? TgtB : TgtA);
  assign rd_addr = {(store_q || phase_q) ? vs2_q : vs1_q, word_q[WordIdxWidth-1:0]};

  // Only read when the target queue has room
  assign rd_want   = busy_q && queue_credit_i[rd_tgt];
  assign rd_fire   = rd_want && !alu_res_req_i && !ldu_req_i;
  assign word_step = rd_fire && (store_q || phase_q);

  assign op_req_ready_o = !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      phase_q <= 1'b0;
      word_q  <= '0;
    end else if (op_req_valid_i && op_req_ready_o) begin
      busy_q  <= 1'b1;
      phase_q <= 1'b0;
      word_q  <= '0;
    end else if (rd_fire) begin
      phase_q <= !store_q && !phase_q;
      if (word_step) begin
        word_q <= word_q + 1'b1;
        if ((word_q + 1'b1) == vl_q) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_req_valid_i && op_req_ready_o) begin
      vs1_q   <= op_req_vs1_i;
      vs2_q   <= op_req_vs2_i;
      vl_q    <= op_req_vl_i;
      store_q <= op_req_store_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // VRF port arbitration
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    vrf_req_o     = 1'b0;
    vrf_wen_o     = 1'b0;
    vrf_addr_o    = rd_addr;
    vrf_wdata_o   = alu_res_wdata_i;
    vrf_be_o      = '1;
    vrf_tgt_o     = rd_tgt;
    alu_res_gnt_o = 1'b0;
    ldu_gnt_o     = 1'b0;
    if (alu_res_req_i) begin
      // Full-word write-back
      vrf_req_o     = 1'b1;
      vrf_wen_o     = 1'b1;
      vrf_addr_o    = alu_res_addr_i;
      alu_res_gnt_o = 1'b1;
    end else if (ldu_req_i) begin
      vrf_req_o   = 1'b1;
      vrf_wen_o   = 1'b1;
      vrf_addr_o  = ldu_addr_i;
      vrf_wdata_o = ldu_wdata_i;
      vrf_be_o    = ldu_be_i;
      ldu_gnt_o   = 1'b1;
    end else if (rd_want) begin
      vrf_req_o = 1'b1;
    end
  end

endmodule

// File: rtl/lane_sequencer.sv
/*
 * Lane sequencer. Holds the running instruction, hands one read command
 * to the operand requester and one command to the ALU, and reports
 * completion from the ALU done pulse or from the store pop count.
 */

`timescale 1ns/100ps

module lane_sequencer import vlane_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [OpWidth-1:0]   pe_req_op_i,
  input  logic [SewWidth-1:0]  pe_req_sew_i,
  input  logic [VRegWidth-1:0] pe_req_vd_i,
  input  logic [VRegWidth-1:0] pe_req_vs1_i,
  input  logic [VRegWidth-1:0] pe_req_vs2_i,
  input  logic [VlWidth-1:0]   pe_req_vl_i,
  input  logic [IdWidth-1:0]   pe_req_id_i,
  input  logic                 pe_req_valid_i,
  output logic                 pe_req_ready_o,
  output logic                 pe_resp_valid_o,
  output logic [IdWidth-1:0]   pe_resp_id_o,
  output logic                 op_req_valid_o,
  input  logic                 op_req_ready_i,
  output logic [VRegWidth-1:0] op_req_vs1_o,
  output logic [VRegWidth-1:0] op_req_vs2_o,
  output logic [VlWidth-1:0]   op_req_vl_o,
  output logic                 op_req_store_o,
  output logic                 alu_cmd_valid_o,
  output logic [OpWidth-1:0]   alu_cmd_op_o,
  output logic [SewWidth-1:0]  alu_cmd_sew_o,
  output logic [VRegWidth-1:0] alu_cmd_vd_o,
  output logic [VlWidth-1:0]   alu_cmd_vl_o,
  input  logic                 alu_done_i,
  input  logic                 stu_pop_i
);

  logic                 busy_q, op_pend_q, alu_pend_q;
  logic [VlWidth-1:0]   pop_cnt_q;
  logic [OpWidth-1:0]   op_q;
  logic [SewWidth-1:0]  sew_q;
  logic [VRegWidth-1:0] vd_q, vs1_q, vs2_q;
  logic [VlWidth-1:0]   vl_q;
  logic [IdWidth-1:0]   id_q;
  logic                 accept, is_store, finish;

  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign is_store       = (op_q == OpStore);

  // Store ends on the last pop, ALU ops on the done pulse
  assign finish = busy_q && (is_store ? (stu_pop_i && ((pop_cnt_q + 1'b1) == vl_q))
                                      : alu_done_i);

  assign pe_resp_valid_o = finish;
  assign pe_resp_id_o    = id_q;

  assign op_req_valid_o = op_pend_q;
  assign op_req_vs1_o   = vs1_q;
  assign op_req_vs2_o   = vs2_q;
  assign op_req_vl_o    = vl_q;
  assign op_req_store_o = is_store;

  assign alu_cmd_valid_o = alu_pend_q;
  assign alu_cmd_op_o    = op_q;
  assign alu_cmd_sew_o   = sew_q;
  assign alu_cmd_vd_o    = vd_q;
  assign alu_cmd_vl_o    = vl_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      op_pend_q  <= 1'b0;
      alu_pend_q <= 1'b0;
      pop_cnt_q  <= '0;
    end else begin
      // ALU command is a single-cycle pulse
      alu_pend_q <= 1'b0;
      if (op_pend_q && op_req_ready_i) op_pend_q <= 1'b0;
      if (stu_pop_i) pop_cnt_q <= pop_cnt_q + 1'b1;
      if (finish) busy_q <= 1'b0;
      if (accept) begin
        busy_q     <= 1'b1;
        op_pend_q  <= 1'b1;
        alu_pend_q <= (pe_req_op_i != OpStore);
        pop_cnt_q  <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= pe_req_op_i;
      sew_q <= pe_req_sew_i;
      vd_q  <= pe_req_vd_i;
      vs1_q <= pe_req_vs1_i;
      vs2_q <= pe_req_vs2_i;
      vl_q  <= pe_req_vl_i;
      id_q  <= pe_req_id_i;
    end
  end

endmodule

// File: rtl/vlane_pkg.sv
/*
 * Shared localparams of the vector lane: datapath and VRF geometry,
 * instruction field widths, operation codes, operand queue sizing and
 * the two-view ALU word.
 */

package vlane_pkg;

  // Datapath
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = ElenWidth / 8;

  // VRF geometry, address is {register, word index}
  localparam int unsigned NrVRegs      = 32;
  localparam int unsigned VRegWords    = 4;
  localparam int unsigned VRegWidth    = 5;
  localparam int unsigned WordIdxWidth = 2;
  localparam int unsigned VAddrWidth   = VRegWidth + WordIdxWidth;

  // Instruction fields, vl is in words (1 to VRegWords)
  localparam int unsigned VlWidth  = 3;
  localparam int unsigned IdWidth  = 3;
  localparam int unsigned OpWidth  = 3;
  localparam int unsigned SewWidth = 1;

  localparam logic [OpWidth-1:0] OpAdd   = 3'd0;
  localparam logic [OpWidth-1:0] OpSub   = 3'd1;
  localparam logic [OpWidth-1:0] OpAnd   = 3'd2;
  localparam logic [OpWidth-1:0] OpOr    = 3'd3;
  localparam logic [OpWidth-1:0] OpXor   = 3'd4;
  localparam logic [OpWidth-1:0] OpStore = 3'd5;

  localparam logic [SewWidth-1:0] Sew16 = 1'b0;
  localparam logic [SewWidth-1:0] Sew32 = 1'b1;

  // Operand queues, depth must be a power of two
  localparam int unsigned QueueDepth = 2;
  localparam int unsigned QPtrWidth  = $clog2(QueueDepth);
  localparam int unsigned QCntWidth  = $clog2(QueueDepth + 1);
  localparam int unsigned NrQueues   = 3;

  // Queue tags carried with each VRF read
  localparam int unsigned TgtWidth = 2;
  localparam logic [TgtWidth-1:0] TgtA  = 2'd0;
  localparam logic [TgtWidth-1:0] TgtB  = 2'd1;
  localparam logic [TgtWidth-1:0] TgtSt = 2'd2;

  // One datapath word, seen as 2 x 32 bit or 4 x 16 bit elements
  typedef union packed {
    logic [ElenWidth-1:0]     w;
    logic [1:0][31:0]         e32;
    logic [3:0][15:0]         e16;
  } alu_word_u;

endpackage
